// File: cache_pkg.sv
// Cache word geometry shared by the store buffer, the forwarding path and the data array
package cache_pkg;

    // Byte address as seen by the LSU
    parameter int ADDR_WIDTH = 32;

    // One cache word
    parameter int DATA_WIDTH = 32;

    // One select bit per byte lane
    parameter int SEL_WIDTH = DATA_WIDTH / 8;

    // Byte lane width
    parameter int BYTE_WIDTH = DATA_WIDTH / SEL_WIDTH;

    // Low address bits that pick a byte inside a word, ignored for word aligned access
    parameter int WORD_OFFSET = $clog2(SEL_WIDTH);

    typedef logic [ADDR_WIDTH-1:0] addr_t;  // Byte address
    typedef logic [DATA_WIDTH-1:0] data_t;  // Cache word
    typedef logic [SEL_WIDTH-1:0]  sel_t;   // Byte mask

endpackage

// File: stb_pkg.sv
// Store buffer defaults and drain FSM states, used by the top level and its submodules
package stb_pkg;

    // Buffer slots, power of two; one slot stays unused to tell full from empty
    parameter int STB_DEPTH_DEF = 8;

    // Cycles one cache write takes
    parameter int DRAIN_LAT_DEF = 3;

    // Data array size in words, power of two
    parameter int MEM_WORDS_DEF = 64;

    // Drain FSM
    typedef enum logic [1:0] {
        IDLE   = 2'd0,  // Waiting for a buffered store
        WRITE  = 2'd1,  // Head presented to the array, latency running
        COMMIT = 2'd2   // Array write and pop
    } drain_state_e;

endpackage

// File: stb_entry_fifo.sv
// Circular store buffer; entries written on the LSU strobe, popped by the drain FSM
`timescale 1ns/1ps

module stb_entry_fifo #(
    parameter int STB_DEPTH = stb_pkg::STB_DEPTH_DEF
) (
    input  logic                          clk,
    input  logic                          rst_n,

    // Store from the LSU
    input  logic                          wr_en,
    input  cache_pkg::addr_t              st_addr,
    input  cache_pkg::data_t              st_wdata,
    input  cache_pkg::sel_t               st_sel,

    // Drain FSM
    input  logic                          rd_en,      // Pop head
    input  logic                          rd_sel,     // Present head

    // Head entry toward the data array
    output cache_pkg::addr_t              head_addr,
    output cache_pkg::data_t              head_wdata,
    output cache_pkg::sel_t               head_sel,

    // Whole buffer toward load forwarding
    output cache_pkg::addr_t              entry_addr  [STB_DEPTH],
    output cache_pkg::data_t              entry_wdata [STB_DEPTH],
    output cache_pkg::sel_t               entry_sel   [STB_DEPTH],
    output logic [$clog2(STB_DEPTH)-1:0]  rd_index,
    output logic [$clog2(STB_DEPTH)-1:0]  wr_index,

    output logic                          stb_full,
    output logic                          stb_empty
);

    localparam int IDX_W = $clog2(STB_DEPTH);

    logic [IDX_W-1:0] wr_index_nxt;  // Slot after the write index, wraps

    // Write index, wraps on its own since depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_index <= '0;
        end else if (wr_en) begin
            wr_index <= wr_index_nxt;
        end
    end

    // Read index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_index <= '0;
        end else if (rd_en) begin
            rd_index <= rd_index + 1'b1;
        end
    end

    // Entry storage, payload only
    always_ff @(posedge clk) begin
        if (wr_en) begin
            entry_addr[wr_index]  <= st_addr;
            entry_wdata[wr_index] <= st_wdata;
            entry_sel[wr_index]   <= st_sel;
        end
    end

    // Head is zero while the drain FSM is not writing
    always_comb begin
        if (rd_sel) begin
            head_addr  = entry_addr[rd_index];
            head_wdata = entry_wdata[rd_index];
            head_sel   = entry_sel[rd_index];
        end else begin
            head_addr  = '0;
            head_wdata = '0;
            head_sel   = '0;
        end
    end

    assign wr_index_nxt = wr_index + 1'b1;
    assign stb_full     = (wr_index_nxt == rd_index);  // Writer one step behind reader
    assign stb_empty    = (wr_index == rd_index);

    // LSU must hold stores off while full
    assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !stb_full)
        else $error("store strobe while buffer full");

    // Drain FSM pops only a real entry
    assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> !stb_empty)
        else $error("pop while buffer empty");

endmodule

// File: stb_load_forward.sv
// Load path that merges the array word with matching buffered stores and registers the result
`timescale 1ns/1ps

module stb_load_forward #(
    parameter int STB_DEPTH = stb_pkg::STB_DEPTH_DEF
) (
    input  logic                          clk,
    input  logic                          rst_n,

    // Load request
    input  logic                          ld_valid,
    input  cache_pkg::addr_t              ld_addr,

    // Array word at ld_addr
    input  cache_pkg::data_t              rd_data,

    // Buffer contents
    input  cache_pkg::addr_t              entry_addr  [STB_DEPTH],
    input  cache_pkg::data_t              entry_wdata [STB_DEPTH],
    input  cache_pkg::sel_t               entry_sel   [STB_DEPTH],
    input  logic [$clog2(STB_DEPTH)-1:0]  rd_index,
    input  logic [$clog2(STB_DEPTH)-1:0]  wr_index,

    // Load result one cycle after the strobe
    output logic                          ld_done,
    output cache_pkg::data_t              ld_data
);

    localparam int IDX_W  = $clog2(STB_DEPTH);
    localparam int ADDR_W = cache_pkg::ADDR_WIDTH;
    localparam int OFF_W  = cache_pkg::WORD_OFFSET;
    localparam int BYTE_W = cache_pkg::BYTE_WIDTH;

    logic [IDX_W-1:0] occupancy;   // Buffered entries
    logic [IDX_W-1:0] slot;        // Slot under inspection
    cache_pkg::data_t merged;      // Array word with forwarded bytes

    assign occupancy = wr_index - rd_index;

    // Oldest to youngest so a later store overwrites an earlier one per byte
    always_comb begin
        merged = rd_data;
        slot   = rd_index;
        for (int k = 0; k < STB_DEPTH; k++) begin
            slot = rd_index + IDX_W'(k);
            if ((IDX_W'(k) < occupancy) &&
                (entry_addr[slot][ADDR_W-1:OFF_W] == ld_addr[ADDR_W-1:OFF_W])) begin
                for (int b = 0; b < cache_pkg::SEL_WIDTH; b++) begin
                    if (entry_sel[slot][b]) begin
                        merged[b*BYTE_W +: BYTE_W] = entry_wdata[slot][b*BYTE_W +: BYTE_W];
                    end
                end
            end
        end
    end

    // Done strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_done <= 1'b0;
        end else begin
            ld_done <= ld_valid;
        end
    end

    // Result word held until the next load
    always_ff @(posedge clk) begin
        if (ld_valid) begin
            ld_data <= merged;
        end
    end

endmodule

// File: dcache_data_array.sv
// Always-hit cache data array; byte-masked writes from the drain path, combinational load read
`timescale 1ns/1ps

module dcache_data_array #(
    parameter int MEM_WORDS = stb_pkg::MEM_WORDS_DEF
) (
    input  logic             clk,
    input  logic             rst_n,

    // Write port, driven by the store buffer head
    input  logic             wr_en,
    input  cache_pkg::addr_t wr_addr,
    input  cache_pkg::data_t wr_data,
    input  cache_pkg::sel_t  wr_sel,

    // Read port for loads
    input  cache_pkg::addr_t rd_addr,
    output cache_pkg::data_t rd_data
);

    localparam int IDX_W  = $clog2(MEM_WORDS);
    localparam int OFF_W  = cache_pkg::WORD_OFFSET;
    localparam int BYTE_W = cache_pkg::BYTE_WIDTH;

    cache_pkg::data_t mem [MEM_WORDS];  // Word storage

    logic [IDX_W-1:0] wr_idx;  // Word index, upper address bits dropped
    logic [IDX_W-1:0] rd_idx;

    assign wr_idx = wr_addr[OFF_W +: IDX_W];
    assign rd_idx = rd_addr[OFF_W +: IDX_W];

    // Cleared at reset, byte lanes written under wr_sel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            for (int b = 0; b < cache_pkg::SEL_WIDTH; b++) begin
                if (wr_sel[b]) begin
                    mem[wr_idx][b*BYTE_W +: BYTE_W] <= wr_data[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    assign rd_data = mem[rd_idx];  // Same-cycle read

    // A commit with no byte selected means the head was not presented
    assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> (wr_sel != '0))
        else $error("array write with empty byte mask");

endmodule

// File: stb_drain_ctrl.sv
// Drain FSM that presents the buffer head for the write latency and then commits and pops it
`timescale 1ns/1ps

module stb_drain_ctrl #(
    parameter int DRAIN_LAT = stb_pkg::DRAIN_LAT_DEF
) (
    input  logic clk,
    input  logic rst_n,

    input  logic stb_empty,  // From the buffer

    output logic rd_sel,     // Present head
    output logic rd_en,      // Pop head
    output logic wr_en       // Array write
);

    // WRITE lasts DRAIN_LAT-1 cycles while the counter runs down to zero
    localparam int unsigned LAST  = (DRAIN_LAT > 1) ? DRAIN_LAT - 2 : 0;
    localparam int          CNT_W = (LAST > 1) ? $clog2(LAST + 1) : 1;

    // Latency 1 skips WRITE entirely
    localparam stb_pkg::drain_state_e START = (DRAIN_LAT > 1) ? stb_pkg::WRITE
                                                               : stb_pkg::COMMIT;

    stb_pkg::drain_state_e state;
    stb_pkg::drain_state_e state_nxt;
    logic [CNT_W-1:0]      lat_cnt;  // Remaining WRITE cycles minus one

    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            stb_pkg::IDLE: begin
                if (!stb_empty) state_nxt = START;
            end
            stb_pkg::WRITE: begin
                if (lat_cnt == '0) state_nxt = stb_pkg::COMMIT;
            end
            stb_pkg::COMMIT: begin
                state_nxt = stb_pkg::IDLE;  // Flags settle after the pop
            end
            default: begin
                state_nxt = stb_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= stb_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Latency counter loaded on the way into WRITE
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lat_cnt <= '0;
        end else if (state != stb_pkg::WRITE) begin
            lat_cnt <= CNT_W'(LAST);
        end else if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - 1'b1;
        end
    end

    assign rd_sel = (state == stb_pkg::WRITE) || (state == stb_pkg::COMMIT);
    assign wr_en  = (state == stb_pkg::COMMIT);  // Commit strobe
    assign rd_en  = wr_en;                        // Pop on the same edge as the write

    // Head held for exactly the write latency before the commit
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rd_sel) |-> ##(DRAIN_LAT-1) rd_en)
        else $error("commit not at write latency");

endmodule

// File: store_buffer_top.sv
// Store buffer top level; joins buffer, drain FSM, load forwarding and the cache data array
`timescale 1ns/1ps

module store_buffer_top #(
    parameter int STB_DEPTH = stb_pkg::STB_DEPTH_DEF,
    parameter int DRAIN_LAT = stb_pkg::DRAIN_LAT_DEF,
    parameter int MEM_WORDS = stb_pkg::MEM_WORDS_DEF
) (
    input  logic             clk,
    input  logic             rst_n,

    // Store strobe from the LSU
    input  logic             st_valid,
    input  cache_pkg::addr_t st_addr,
    input  cache_pkg::data_t st_wdata,
    input  cache_pkg::sel_t  st_sel,

    // Load strobe from the LSU
    input  logic             ld_valid,
    input  cache_pkg::addr_t ld_addr,

    output logic             ld_done,
    output cache_pkg::data_t ld_data,
    output logic             stb_full,
    output logic             stb_empty
);

    localparam int IDX_W = $clog2(STB_DEPTH);

    cache_pkg::addr_t head_addr;
    cache_pkg::data_t head_wdata;
    cache_pkg::sel_t  head_sel;
    cache_pkg::addr_t entry_addr  [STB_DEPTH];
    cache_pkg::data_t entry_wdata [STB_DEPTH];
    cache_pkg::sel_t  entry_sel   [STB_DEPTH];
    logic [IDX_W-1:0] rd_index;
    logic [IDX_W-1:0] wr_index;
    logic             rd_sel;
    logic             rd_en;
    logic             cache_wr_en;  // Array write strobe from the drain FSM
    cache_pkg::data_t rd_data;      // Array word for the current load

    stb_entry_fifo #(.STB_DEPTH(STB_DEPTH)) stb_entry_fifo_inst (
        .clk(clk), .rst_n(rst_n),
        .wr_en(st_valid), .st_addr(st_addr), .st_wdata(st_wdata), .st_sel(st_sel),
        .rd_en(rd_en), .rd_sel(rd_sel),
        .head_addr(head_addr), .head_wdata(head_wdata), .head_sel(head_sel),
        .entry_addr(entry_addr), .entry_wdata(entry_wdata), .entry_sel(entry_sel),
        .rd_index(rd_index), .wr_index(wr_index),
        .stb_full(stb_full), .stb_empty(stb_empty)
    );

    stb_drain_ctrl #(.DRAIN_LAT(DRAIN_LAT)) stb_drain_ctrl_inst (
        .clk(clk), .rst_n(rst_n), .stb_empty(stb_empty),
        .rd_sel(rd_sel), .rd_en(rd_en), .wr_en(cache_wr_en)
    );

    dcache_data_array #(.MEM_WORDS(MEM_WORDS)) dcache_data_array_inst (
        .clk(clk), .rst_n(rst_n),
        .wr_en(cache_wr_en), .wr_addr(head_addr), .wr_data(head_wdata), .wr_sel(head_sel),
        .rd_addr(ld_addr), .rd_data(rd_data)
    );

    stb_load_forward #(.STB_DEPTH(STB_DEPTH)) stb_load_forward_inst (
        .clk(clk), .rst_n(rst_n),
        .ld_valid(ld_valid), .ld_addr(ld_addr), .rd_data(rd_data),
        .entry_addr(entry_addr), .entry_wdata(entry_wdata), .entry_sel(entry_sel),
        .rd_index(rd_index), .wr_index(wr_index),
        .ld_done(ld_done), .ld_data(ld_data)
    );

endmodule

// File: tb_store_buffer.sv
// Self-checking testbench that runs an operation table on store_buffer_top against a byte model
`timescale 1ns/1ps

module tb_store_buffer;

    localparam int STB_DEPTH  = stb_pkg::STB_DEPTH_DEF;
    localparam int DRAIN_LAT  = stb_pkg::DRAIN_LAT_DEF;
    localparam int MEM_WORDS  = stb_pkg::MEM_WORDS_DEF;
    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 2;      // Input skew after the rising edge
    localparam int RST_CYCLES = 3;
    localparam int NUM_ROWS   = 96;
    localparam int BYTE_W     = cache_pkg::BYTE_WIDTH;
    localparam int REF_IDX_W  = 6;      // Test addresses stay below 256 bytes
    localparam int DRAIN_WAIT = STB_DEPTH * (DRAIN_LAT + 1) + 8;  // IDLE, WRITE and COMMIT per entry
    localparam int TIMEOUT_CYCLES = NUM_ROWS * (STB_DEPTH * (DRAIN_LAT + 1) + 4);
    localparam logic [31:0] RAND_SEED = 32'h25ae50ca;
    localparam int RAND_BASE  = 32'h80;  // Random traffic on four words from here

    typedef enum logic [2:0] {
        OP_STORE,   // Store strobe that waits while full
        OP_LOAD,    // Load strobe with data checked one cycle later
        OP_IDLE,    // Idle for data cycles
        OP_FLAGS,   // Flags against data[1] as full and data[0] as empty
        OP_FILLCHK  // Full seen during the last burst
    } op_e;

    logic             clk;
    logic             rst_n;
    logic             st_valid;
    cache_pkg::addr_t st_addr;
    cache_pkg::data_t st_wdata;
    cache_pkg::sel_t  st_sel;
    logic             ld_valid;
    cache_pkg::addr_t ld_addr;
    logic             ld_done;
    cache_pkg::data_t ld_data;
    logic             stb_full;
    logic             stb_empty;

    // Operation table
    op_e              tbl_op   [NUM_ROWS];
    cache_pkg::addr_t tbl_addr [NUM_ROWS];
    cache_pkg::data_t tbl_data [NUM_ROWS];
    cache_pkg::sel_t  tbl_sel  [NUM_ROWS];
    cache_pkg::data_t tbl_exp  [NUM_ROWS];
    int               tbl_test [NUM_ROWS];
    int               n_rows;

    logic [BYTE_W-1:0] ref_mem [2**REF_IDX_W][cache_pkg::SEL_WIDTH];  // Program-order byte model
    string             test_name [1:6];

    int checks;
    int errors;
    int test_checks;
    int test_errors;
    int cur_test;
    int tests_run;
    int cycle_count;
    int burst_stores;       // Stores since the buffer was last seen empty
    int stores_at_full;
    logic full_seen;

    store_buffer_top #(
        .STB_DEPTH(STB_DEPTH), .DRAIN_LAT(DRAIN_LAT), .MEM_WORDS(MEM_WORDS)
    ) store_buffer_top_inst (
        .clk(clk), .rst_n(rst_n),
        .st_valid(st_valid), .st_addr(st_addr), .st_wdata(st_wdata), .st_sel(st_sel),
        .ld_valid(ld_valid), .ld_addr(ld_addr),
        .ld_done(ld_done), .ld_data(ld_data), .stb_full(stb_full), .stb_empty(stb_empty)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    function automatic cache_pkg::data_t ref_word(input int w);
        cache_pkg::data_t word;
        for (int b = 0; b < cache_pkg::SEL_WIDTH; b++) begin
            word[b*BYTE_W +: BYTE_W] = ref_mem[w][b];
        end
        return word;
    endfunction

    // Stores to fill an empty buffer while the drain pops one entry every DRAIN_LAT+1 cycles
    function automatic int fill_store_count();
        int n;
        n = 0;
        while (n - ((n > 0) ? (n - 1) / (DRAIN_LAT + 1) : 0) < STB_DEPTH - 1) begin
            n++;
        end
        return n;
    endfunction

    // Stores update the model and loads take their expected word from it
    task automatic add_row(input op_e op, input cache_pkg::addr_t addr,
                           input cache_pkg::data_t data, input cache_pkg::sel_t sel,
                           input int test);
        int w;
        w = int'(addr[cache_pkg::WORD_OFFSET +: REF_IDX_W]);
        tbl_op[n_rows]   = op;
        tbl_addr[n_rows] = addr;
        tbl_data[n_rows] = data;
        tbl_sel[n_rows]  = sel;
        tbl_test[n_rows] = test;
        tbl_exp[n_rows]  = data;  // Idle length or flag pattern
        if (op == OP_STORE) begin
            for (int b = 0; b < cache_pkg::SEL_WIDTH; b++) begin
                if (sel[b]) ref_mem[w][b] = data[b*BYTE_W +: BYTE_W];
            end
        end else if (op == OP_LOAD) begin
            tbl_exp[n_rows] = ref_word(w);
        end
        n_rows++;
    endtask

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic note_full();
        if (stb_full && !full_seen) begin
            full_seen      = 1'b1;
            stores_at_full = burst_stores;
        end
    endtask

    task automatic check_flags(input logic exp_full, input logic exp_empty);
        checks++;
        test_checks++;
        if (stb_full !== exp_full || stb_empty !== exp_empty || ld_done !== 1'b0) begin
            $display("ERROR %0d ns: full=%b empty=%b done=%b, expected full=%b empty=%b done=0",
                     $time, stb_full, stb_empty, ld_done, exp_full, exp_empty);
            note_error();
        end
        if (stb_empty) begin  // New fill burst starts here
            burst_stores = 0;
            full_seen    = 1'b0;
        end
    endtask

    task automatic apply_store(input int r);
        note_full();
        while (stb_full) begin  // LSU holds off while full
            @(posedge clk);
            #DRIVE_DLY;
        end
        st_valid = 1'b1;
        st_addr  = tbl_addr[r];
        st_wdata = tbl_data[r];
        st_sel   = tbl_sel[r];
        @(posedge clk);
        #DRIVE_DLY;
        st_valid = 1'b0;
        burst_stores++;
    endtask

    task automatic apply_load(input int r);
        ld_valid = 1'b1;
        ld_addr  = tbl_addr[r];
        @(posedge clk);
        #DRIVE_DLY;
        ld_valid = 1'b0;
        checks++;
        test_checks++;
        if (ld_done !== 1'b1) begin
            $display("ERROR %0d ns: no ld_done one cycle after load of 0x%08h", $time, tbl_addr[r]);
            note_error();
        end else if (ld_data !== tbl_exp[r]) begin
            $display("ERROR %0d ns: load 0x%08h returned 0x%08h, expected 0x%08h",
                     $time, tbl_addr[r], ld_data, tbl_exp[r]);
            note_error();
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic check_fill();
        note_full();
        checks++;
        test_checks++;
        if (!full_seen) begin
            $display("ERROR %0d ns: buffer never reported full during back-to-back stores", $time);
            note_error();
        end else if (stores_at_full != fill_store_count()) begin
            $display("ERROR %0d ns: full after %0d stores, expected %0d", $time,
                     stores_at_full, fill_store_count());
            note_error();
        end
    endtask

    task automatic finish_test();
        $display("[test %0d] %s: %0d checks, %0d errors, %s", cur_test, test_name[cur_test],
                 test_checks, test_errors, (test_errors == 0) ? "ok" : "FAIL");
        tests_run++;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic build_table();
        int pick;
        cache_pkg::addr_t addr;
        // 1 reset values
        add_row(OP_FLAGS, '0, 32'h1, '0, 1);
        add_row(OP_IDLE, '0, 32'd2, '0, 1);
        add_row(OP_FLAGS, '0, 32'h1, '0, 1);
        // 2 forwarding right behind the store
        add_row(OP_STORE, 32'h10, 32'hdeadbeef, 4'hf, 2);
        add_row(OP_LOAD, 32'h10, '0, '0, 2);
        add_row(OP_STORE, 32'h14, 32'h01234567, 4'hf, 2);
        add_row(OP_LOAD, 32'h14, '0, '0, 2);
        add_row(OP_LOAD, 32'h10, '0, '0, 2);
        add_row(OP_STORE, 32'h10, 32'hcafef00d, 4'b1100, 2);
        add_row(OP_LOAD, 32'h10, '0, '0, 2);
        // 3 partial stores over a drained word
        add_row(OP_STORE, 32'h20, 32'h11223344, 4'hf, 3);
        add_row(OP_IDLE, '0, DRAIN_WAIT, '0, 3);
        add_row(OP_STORE, 32'h20, 32'haaaaaaaa, 4'b0001, 3);
        add_row(OP_STORE, 32'h20, 32'hbbbbbbbb, 4'b0110, 3);
        add_row(OP_STORE, 32'h20, 32'hcccccccc, 4'b0011, 3);
        add_row(OP_STORE, 32'h24, 32'h55555555, 4'b1000, 3);  // Neighbour word that must not match
        add_row(OP_LOAD, 32'h20, '0, '0, 3);
        add_row(OP_LOAD, 32'h23, '0, '0, 3);  // Byte offset ignored
        // 4 fill until full and drain again
        add_row(OP_IDLE, '0, DRAIN_WAIT, '0, 4);
        add_row(OP_FLAGS, '0, 32'h1, '0, 4);
        for (int k = 0; k < STB_DEPTH + 4; k++) begin
            add_row(OP_STORE, cache_pkg::addr_t'(32'h40 + 4 * k), 32'h5a000000 + k, 4'hf, 4);
        end
        add_row(OP_FILLCHK, '0, '0, '0, 4);
        add_row(OP_LOAD, 32'h44, '0, '0, 4);
        add_row(OP_IDLE, '0, DRAIN_WAIT, '0, 4);
        add_row(OP_FLAGS, '0, 32'h1, '0, 4);
        // 5 array alone after a full drain
        add_row(OP_STORE, 32'h30, 32'h0badf00d, 4'hf, 5);
        add_row(OP_STORE, 32'h34, 32'h87654321, 4'b0101, 5);
        add_row(OP_IDLE, '0, DRAIN_WAIT, '0, 5);
        add_row(OP_FLAGS, '0, 32'h1, '0, 5);
        add_row(OP_LOAD, 32'h10, '0, '0, 5);
        add_row(OP_LOAD, 32'h14, '0, '0, 5);
        add_row(OP_LOAD, 32'h20, '0, '0, 5);
        add_row(OP_LOAD, 32'h24, '0, '0, 5);
        add_row(OP_LOAD, 32'h30, '0, '0, 5);
        add_row(OP_LOAD, 32'h34, '0, '0, 5);
        add_row(OP_LOAD, 32'h40, '0, '0, 5);
        add_row(OP_LOAD, 32'h6c, '0, '0, 5);
        // 6 random tail
        while (n_rows < NUM_ROWS) begin
            pick = int'($urandom_range(0, 9));
            addr = cache_pkg::addr_t'(RAND_BASE + 4 * $urandom_range(0, 3));
            if (pick < 5) begin
                add_row(OP_STORE, addr, $urandom(), cache_pkg::sel_t'($urandom_range(1, 15)), 6);
            end else if (pick < 9) begin
                add_row(OP_LOAD, addr, '0, '0, 6);
            end else begin
                add_row(OP_IDLE, '0, cache_pkg::data_t'($urandom_range(1, 3)), '0, 6);
            end
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        st_valid = 1'b0;
        st_addr  = '0;
        st_wdata = '0;
        st_sel   = '0;
        ld_valid = 1'b0;
        ld_addr  = '0;
        checks         = 0;
        errors         = 0;
        test_checks    = 0;
        test_errors    = 0;
        tests_run      = 0;
        cycle_count    = 0;
        n_rows         = 0;
        burst_stores   = 0;
        stores_at_full = 0;
        full_seen      = 1'b0;
        cur_test = 1;
        test_name[1] = "reset values";
        test_name[2] = "store to load forwarding";
        test_name[3] = "byte merge";
        test_name[4] = "fill and full";
        test_name[5] = "drain to array";
        test_name[6] = "random mix";
        for (int w = 0; w < 2**REF_IDX_W; w++) begin
            for (int b = 0; b < cache_pkg::SEL_WIDTH; b++) begin
                ref_mem[w][b] = '0;  // Array clears at reset
            end
        end
        void'($urandom(RAND_SEED));
        build_table();

        wait_cycles(RST_CYCLES);
        check_flags(1'b0, 1'b1);  // Still in reset
        rst_n = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            if (tbl_test[r] != cur_test) begin
                finish_test();
                cur_test = tbl_test[r];
            end
            case (tbl_op[r])
                OP_STORE:   apply_store(r);
                OP_LOAD:    apply_load(r);
                OP_IDLE:    wait_cycles(int'(tbl_data[r]));
                OP_FLAGS:   check_flags(tbl_exp[r][1], tbl_exp[r][0]);
                default:    check_fill();
            endcase
        end
        finish_test();

        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sim.f
cache_pkg.sv
stb_pkg.sv
stb_entry_fifo.sv
stb_load_forward.sv
dcache_data_array.sv
stb_drain_ctrl.sv
store_buffer_top.sv
tb_store_buffer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the store buffer testbench with Verilator, runs it and looks for the pass message
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f sim.f --top-module tb_store_buffer --Mdir obj_dir

output=$(./obj_dir/Vtb_store_buffer 2>&1) || true
echo "$output"

if grep -qx "Test passed" <<< "$output"; then
    exit 0
fi
exit 1
